// File: project.f
src/isa_pkg.sv
src/rename_pkg.sv
src/instr_decoder.sv
src/free_list.sv
src/register_rename.sv
src/issue_pipeline.sv
src/issue_stage.sv
bench/clock_gen.sv
bench/issue_stage_tb.sv

// File: Makefile
TB_TOP = issue_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module issue_stage

sim:
	verilator --binary --timing -j 0 -f project.f --top-module $(TB_TOP) -o sim_bin
	@out="$$(./obj_dir/sim_bin)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: bench/issue_stage_tb.sv
`timescale 1ns/100ps

module issue_stage_tb;

    import isa_pkg::*;
    import rename_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic                          clk;
    logic                          reset;
    logic [LANES-1:0][XLEN-1:0]    instr;
    logic [LANES-1:0][XLEN-1:0]    pc;
    logic [LANES-1:0]              decode_valid;
    logic [LANES-1:0]              dispatch_ready;
    logic                          flush;
    logic                          bubble;
    logic [LANES-1:0]              commit_valid;
    logic [LANES-1:0][PHYS_W-1:0]  commit_phys;
    logic                          decode_ready;
    logic [LANES-1:0]              issue_valid;
    logic [LANES-1:0][CLASS_W-1:0] iss_class;
    logic [LANES-1:0]              iss_writes;
    logic [LANES-1:0][XLEN-1:0]    iss_imm;
    logic [LANES-1:0][PHYS_W-1:0]  iss_rs1;
    logic [LANES-1:0][PHYS_W-1:0]  iss_rs2;
    logic [LANES-1:0][PHYS_W-1:0]  iss_rd;
    logic [LANES-1:0][ARCH_W-1:0]  iss_rd_arch;
    logic [LANES-1:0][XLEN-1:0]    iss_pc;

    // Reference model of the alias table and free list
    int          rat [ARCH_REGS];
    int          free_q [$];
    int          retired_q [$];
    logic [31:0] exp_class [LANES];
    logic [31:0] exp_writes [LANES];
    logic [31:0] exp_imm [LANES];
    logic [31:0] exp_rs1 [LANES];
    logic [31:0] exp_rs2 [LANES];
    logic [31:0] exp_rd [LANES];
    logic [31:0] pc_base = 32'h1000;
    int          seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    clock_gen u_clock (.clk_o(clk), .reset_o(reset));

    issue_stage UUT (
        .clk(clk), .reset(reset), .instr_i(instr), .pc_i(pc),
        .decode_valid_i(decode_valid), .dispatch_ready_i(dispatch_ready),
        .flush_i(flush), .bubble_i(bubble),
        .commit_valid_i(commit_valid), .commit_phys_i(commit_phys),
        .decode_ready_o(decode_ready), .issue_valid_o(issue_valid),
        .class_o(iss_class), .writes_rd_o(iss_writes), .immediate_o(iss_imm),
        .rs1_phys_o(iss_rs1), .rs2_phys_o(iss_rs2), .rd_phys_o(iss_rd),
        .rd_arch_o(iss_rd_arch), .pc_o(iss_pc)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // ==============================
    // Decode rules
    // ==============================
    function automatic logic [31:0] class_of(logic [6:0] opcode);
        case (opcode)
            OP_REG:           return 32'(CLS_ALU);
            OP_IMM:           return 32'(CLS_ALU_IMM);
            OP_LOAD:          return 32'(CLS_LOAD);
            OP_STORE:         return 32'(CLS_STORE);
            OP_BRANCH:        return 32'(CLS_BRANCH);
            OP_JAL, OP_JALR:  return 32'(CLS_JUMP);
            OP_LUI, OP_AUIPC: return 32'(CLS_UPPER);
            default:          return 32'(CLS_ILLEGAL);
        endcase
    endfunction

    function automatic logic [31:0] imm_of(logic [31:0] word);
        if (word[6:0] == OP_IMM || word[6:0] == OP_LOAD || word[6:0] == OP_JALR) begin
            return {{20{word[31]}}, word[31:20]};
        end
        return 32'd0;
    endfunction

    // Random fields in x0..x7 so lanes often share registers
    task automatic prepare_group(input logic [6:0] op0, input logic [6:0] op1,
                                 input logic [6:0] op2);
        logic [6:0]  ops [LANES];
        logic [31:0] r;
        ops = '{op0, op1, op2};
        for (int k = 0; k < LANES; k++) begin
            r        = $random(seed);
            instr[k] = {r[27:21], 2'b00, r[8:6], 2'b00, r[5:3], 3'b000, 2'b00, r[2:0], ops[k]};
            pc[k]    = pc_base + 32'(4 * k);
        end
        pc_base = pc_base + 32'h10;
    endtask

    // Expected renames of the driven group, then the table update
    task automatic model_group(input logic [LANES-1:0] valid);
        logic [4:0] rd [LANES];
        logic       wr [LANES];
        logic [4:0] rs1;
        logic [4:0] rs2;
        for (int k = 0; k < LANES; k++) begin
            rd[k]         = instr[k][11:7];
            rs1           = instr[k][19:15];
            rs2           = instr[k][24:20];
            exp_class[k]  = class_of(instr[k][6:0]);
            exp_writes[k] = 32'(exp_class[k] inside {CLS_ALU, CLS_ALU_IMM, CLS_LOAD,
                                CLS_JUMP, CLS_UPPER} && rd[k] != 5'd0);
            exp_imm[k]    = imm_of(instr[k]);
            wr[k]         = valid[k] && exp_writes[k][0];
            exp_rs1[k]    = (rs1 == 5'd0) ? 32'd0 : rat[rs1];
            exp_rs2[k]    = (rs2 == 5'd0) ? 32'd0 : rat[rs2];
            for (int j = 0; j < k; j++) begin
                if (wr[j] && rd[j] == rs1) exp_rs1[k] = exp_rd[j];
                if (wr[j] && rd[j] == rs2) exp_rs2[k] = exp_rd[j];
            end
            exp_rd[k] = wr[k] ? free_q.pop_front() : 32'd0;
        end
        for (int k = 0; k < LANES; k++) begin
            if (wr[k]) begin
                retired_q.push_back(rat[rd[k]]);
                rat[rd[k]] = exp_rd[k];
            end
        end
    endtask

    task automatic check_lane(input int k, input logic [31:0] word, input logic [31:0] lane_pc);
        compare($sformatf("class_o[%0d]", k), 32'(iss_class[k]), exp_class[k]);
        compare($sformatf("writes_rd_o[%0d]", k), 32'(iss_writes[k]), exp_writes[k]);
        compare($sformatf("immediate_o[%0d]", k), iss_imm[k], exp_imm[k]);
        compare($sformatf("rs1_phys_o[%0d]", k), 32'(iss_rs1[k]), exp_rs1[k]);
        compare($sformatf("rs2_phys_o[%0d]", k), 32'(iss_rs2[k]), exp_rs2[k]);
        compare($sformatf("rd_phys_o[%0d]", k), 32'(iss_rd[k]), exp_rd[k]);
        compare($sformatf("rd_arch_o[%0d]", k), 32'(iss_rd_arch[k]), 32'(word[11:7]));
        compare($sformatf("pc_o[%0d]", k), iss_pc[k], lane_pc);
    endtask

    // Offer the prepared group, wait for acceptance, check one edge later
    task automatic run_group(input logic [LANES-1:0] valid);
        decode_valid = valid;
        @(negedge clk);
        while (!decode_ready) begin
            @(negedge clk);
        end
        if (free_q.size() < LANES) begin
            errors++;
            $display("Group accepted while fewer than three registers were free");
        end
        model_group(valid);
        @(posedge clk);
        #2;
        decode_valid = '0;
        compare("issue_valid_o", 32'(issue_valid), 32'(valid));
        for (int k = 0; k < LANES; k++) begin
            if (valid[k]) check_lane(k, instr[k], pc[k]);
        end
    endtask

    // Hand back up to three unmapped registers, oldest first
    task automatic commit_retired();
        commit_valid = '0;
        for (int k = 0; k < LANES; k++) begin
            if (retired_q.size() > 0) begin
                commit_valid[k] = 1'b1;
                commit_phys[k]  = PHYS_W'(retired_q.pop_front());
                free_q.push_back(int'(commit_phys[k]));
            end
        end
        @(posedge clk);
        #2;
        commit_valid = '0;
    endtask

    task automatic expect_ready(input logic level);
        @(negedge clk);
        compare("decode_ready_o", 32'(decode_ready), 32'(level));
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset();
        compare("issue_valid_o", 32'(issue_valid), 32'd0);
        for (int k = 0; k < LANES; k++) begin
            compare($sformatf("fields[%0d]", k), 32'(iss_class[k]) | 32'(iss_writes[k]) |
                    iss_imm[k] | 32'(iss_rs1[k]) | 32'(iss_rs2[k]) | 32'(iss_rd[k]) |
                    32'(iss_rd_arch[k]) | iss_pc[k], 32'd0);
        end
        expect_ready(1'b1);
        @(posedge clk);
        #2;
    endtask

    task automatic test_decode();
        logic [6:0] ops [10];
        ops = '{OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH, OP_JAL, OP_JALR,
                OP_LUI, OP_AUIPC, 7'h7f};
        for (int i = 0; i < 10; i++) begin
            prepare_group(ops[i], ops[(i + 3) % 10], ops[(i + 7) % 10]);
            run_group(3'b111);
            commit_retired();
        end
    endtask

    task automatic test_rename();
        logic [31:0] r;
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            prepare_group(OP_REG, r[0] ? OP_IMM : OP_STORE, OP_LOAD);
            run_group((r[3:1] == 3'b000) ? 3'b101 : 3'b111);
            commit_retired();
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] held_instr;
        logic [31:0] held_pc;
        prepare_group(OP_REG, OP_REG, OP_REG);
        run_group(3'b111);
        held_instr     = instr[1];
        held_pc        = pc[1];
        dispatch_ready = 3'b101;
        prepare_group(OP_IMM, OP_LOAD, OP_REG);
        decode_valid = 3'b111;
        for (int n = 0; n < 2; n++) begin
            expect_ready(1'b0);
            @(posedge clk);
            #2;
            compare("issue_valid_o", 32'(issue_valid), 32'b010);
            // Stalled lane keeps every field of the first group
            check_lane(1, held_instr, held_pc);
        end
        dispatch_ready = '1;
        run_group(3'b111);
        commit_retired();
    endtask

    task automatic test_exhaust();
        while (free_q.size() >= LANES) begin
            prepare_group(OP_REG, OP_IMM, OP_LOAD);
            run_group(3'b111);
        end
        prepare_group(OP_LOAD, OP_REG, OP_IMM);
        decode_valid = 3'b111;
        expect_ready(1'b0);
        @(posedge clk);
        #2;
        decode_valid = '0;
        commit_retired();
        expect_ready(1'b1);
        @(posedge clk);
        #2;
        run_group(3'b111);
        while (retired_q.size() > 0) begin
            commit_retired();
        end
    endtask

    task automatic test_flush_bubble();
        for (int mode = 0; mode < 2; mode++) begin
            prepare_group(OP_REG, OP_IMM, OP_REG);
            run_group(3'b111);
            prepare_group(OP_LOAD, OP_REG, OP_IMM);
            flush          = (mode == 0);
            bubble         = (mode == 1);
            // Stalled lanes would hold, so only the flush or bubble clears them
            dispatch_ready = '0;
            decode_valid   = 3'b111;
            @(posedge clk);
            #2;
            compare("issue_valid_o", 32'(issue_valid), 32'd0);
            dispatch_ready = '1;
            expect_ready(1'b0);
            @(posedge clk);
            #2;
            flush  = 1'b0;
            bubble = 1'b0;
            run_group(3'b111);
            commit_retired();
        end
    endtask

    initial begin
        seed           = 78;
        instr          = '0;
        pc             = '0;
        decode_valid   = '0;
        dispatch_ready = '1;
        flush          = 1'b0;
        bubble         = 1'b0;
        commit_valid   = '0;
        commit_phys    = '0;
        for (int r = 0; r < ARCH_REGS; r++) rat[r] = r;
        for (int p = ARCH_REGS; p < PHYS_REGS; p++) free_q.push_back(p);
        @(posedge reset);
        @(posedge clk);
        #2;
        test_reset();
        test_decode();
        test_rename();
        test_backpressure();
        test_exhaust();
        test_flush_bubble();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Active-low reset held over four rising edges
    initial begin
        reset_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #2 reset_o = 1'b1;
    end

endmodule

// File: src/issue_stage.sv
`timescale 1ns/100ps

module issue_stage (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        instr_i,
    input  logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        pc_i,
    input  logic [rename_pkg::LANES-1:0]                           decode_valid_i,
    input  logic [rename_pkg::LANES-1:0]                           dispatch_ready_i,
    input  logic                                                   flush_i,
    input  logic                                                   bubble_i,
    input  logic [rename_pkg::LANES-1:0]                           commit_valid_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   commit_phys_i,
    output logic                                                   decode_ready_o,
    output logic [rename_pkg::LANES-1:0]                           issue_valid_o,
    output logic [rename_pkg::LANES-1:0][isa_pkg::CLASS_W-1:0]     class_o,
    output logic [rename_pkg::LANES-1:0]                           writes_rd_o,
    output logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        immediate_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs1_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs2_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rd_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::ARCH_W-1:0]   rd_arch_o,
    output logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        pc_o
);

    import isa_pkg::*;
    import rename_pkg::*;

    // Decoder results per lane
    logic [LANES-1:0][CLASS_W-1:0]  dec_class;
    logic [LANES-1:0]               dec_writes;
    logic [LANES-1:0][ARCH_W-1:0]   dec_rs1;
    logic [LANES-1:0][ARCH_W-1:0]   dec_rs2;
    logic [LANES-1:0][ARCH_W-1:0]   dec_rd;
    logic [LANES-1:0][XLEN-1:0]     dec_imm;

    // Renamed registers
    logic [LANES-1:0][PHYS_W-1:0]   ren_rs1;
    logic [LANES-1:0][PHYS_W-1:0]   ren_rs2;
    logic [LANES-1:0][PHYS_W-1:0]   ren_rd;

    logic                           stage_ready;
    logic                           accept;

    // ==============================
    // Decoders
    // ==============================
    for (genvar k = 0; k < LANES; k++) begin : g_dec
        instr_decoder u_dec (
            .instr_i     (instr_i[k]),
            .class_o     (dec_class[k]),
            .writes_rd_o (dec_writes[k]),
            .rs1_o       (dec_rs1[k]),
            .rs2_o       (dec_rs2[k]),
            .rd_o        (dec_rd[k]),
            .immediate_o (dec_imm[k])
        );
    end

    // ==============================
    // Rename and issue
    // ==============================
    register_rename u_rename (
        .clk            (clk),
        .reset          (reset),
        .decode_valid_i (decode_valid_i),
        .stage_ready_i  (stage_ready),
        .class_i        (dec_class),
        .writes_rd_i    (dec_writes),
        .rs1_i          (dec_rs1),
        .rs2_i          (dec_rs2),
        .rd_i           (dec_rd),
        .commit_valid_i (commit_valid_i),
        .commit_phys_i  (commit_phys_i),
        .decode_ready_o (decode_ready_o),
        .accept_o       (accept),
        .rs1_phys_o     (ren_rs1),
        .rs2_phys_o     (ren_rs2),
        .rd_phys_o      (ren_rd)
    );

    issue_pipeline u_issue (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .bubble_i         (bubble_i),
        .dispatch_ready_i (dispatch_ready_i),
        .accept_i         (accept),
        .decode_valid_i   (decode_valid_i),
        .class_i          (dec_class),
        .writes_rd_i      (dec_writes),
        .immediate_i      (dec_imm),
        .rd_arch_i        (dec_rd),
        .pc_i             (pc_i),
        .rs1_phys_i       (ren_rs1),
        .rs2_phys_i       (ren_rs2),
        .rd_phys_i        (ren_rd),
        .stage_ready_o    (stage_ready),
        .issue_valid_o    (issue_valid_o),
        .class_o          (class_o),
        .writes_rd_o      (writes_rd_o),
        .immediate_o      (immediate_o),
        .rs1_phys_o       (rs1_phys_o),
        .rs2_phys_o       (rs2_phys_o),
        .rd_phys_o        (rd_phys_o),
        .rd_arch_o        (rd_arch_o),
        .pc_o             (pc_o)
    );

endmodule

// File: src/issue_pipeline.sv
`timescale 1ns/100ps

module issue_pipeline (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic                                                   flush_i,
    input  logic                                                   bubble_i,
    input  logic [rename_pkg::LANES-1:0]                           dispatch_ready_i,
    input  logic                                                   accept_i,
    input  logic [rename_pkg::LANES-1:0]                           decode_valid_i,
    input  logic [rename_pkg::LANES-1:0][isa_pkg::CLASS_W-1:0]     class_i,
    input  logic [rename_pkg::LANES-1:0]                           writes_rd_i,
    input  logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        immediate_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::ARCH_W-1:0]   rd_arch_i,
    input  logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        pc_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs1_phys_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs2_phys_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rd_phys_i,
    output logic                                                   stage_ready_o,
    output logic [rename_pkg::LANES-1:0]                           issue_valid_o,
    output logic [rename_pkg::LANES-1:0][isa_pkg::CLASS_W-1:0]     class_o,
    output logic [rename_pkg::LANES-1:0]                           writes_rd_o,
    output logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        immediate_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs1_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs2_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rd_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::ARCH_W-1:0]   rd_arch_o,
    output logic [rename_pkg::LANES-1:0][isa_pkg::XLEN-1:0]        pc_o
);

    // A new group needs every lane drained and no flush or bubble pending
    assign stage_ready_o = (&dispatch_ready_i) && !flush_i && !bubble_i;

    // ==============================
    // Issue registers
    // ==============================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_valid_o <= '0;
            class_o       <= '0;
            writes_rd_o   <= '0;
            immediate_o   <= '0;
            rs1_phys_o    <= '0;
            rs2_phys_o    <= '0;
            rd_phys_o     <= '0;
            rd_arch_o     <= '0;
            pc_o          <= '0;
        end else if (flush_i || bubble_i) begin
            issue_valid_o <= '0;
        end else if (accept_i) begin
            issue_valid_o <= decode_valid_i;
            class_o       <= class_i;
            writes_rd_o   <= writes_rd_i;
            immediate_o   <= immediate_i;
            rs1_phys_o    <= rs1_phys_i;
            rs2_phys_o    <= rs2_phys_i;
            rd_phys_o     <= rd_phys_i;
            rd_arch_o     <= rd_arch_i;
            pc_o          <= pc_i;
        end else begin
            // Stalled lanes keep their contents for dispatch
            issue_valid_o <= issue_valid_o & ~dispatch_ready_i;
        end
    end

endmodule

// File: src/register_rename.sv
`timescale 1ns/100ps

module register_rename (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic [rename_pkg::LANES-1:0]                           decode_valid_i,
    input  logic                                                   stage_ready_i,
    input  logic [rename_pkg::LANES-1:0][isa_pkg::CLASS_W-1:0]     class_i,
    input  logic [rename_pkg::LANES-1:0]                           writes_rd_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::ARCH_W-1:0]   rs1_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::ARCH_W-1:0]   rs2_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::ARCH_W-1:0]   rd_i,
    input  logic [rename_pkg::LANES-1:0]                           commit_valid_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   commit_phys_i,
    output logic                                                   decode_ready_o,
    output logic                                                   accept_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs1_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rs2_phys_o,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]   rd_phys_o
);

    import isa_pkg::*;
    import rename_pkg::*;

    // x0 stays mapped to physical 0 since no lane ever writes it
    logic [PHYS_W-1:0]               rat_q [ARCH_REGS];
    logic [LANES-1:0]                lane_wr;
    logic [LANES-1:0]                pop;
    logic [LANES-1:0][PHYS_W-1:0]    head_phys;
    logic [FREE_CNT_W-1:0]           free_cnt;

    // Illegal lanes never allocate
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            lane_wr[k] = decode_valid_i[k] && writes_rd_i[k] && (class_i[k] != CLS_ILLEGAL);
        end
    end

    // ==============================
    // Group acceptance
    // ==============================
    assign decode_ready_o = stage_ready_i && (free_cnt >= FREE_CNT_W'(LANES));
    assign accept_o       = decode_ready_o && (|decode_valid_i);
    assign pop            = accept_o ? lane_wr : '0;

    // ==============================
    // Allocation and forwarding
    // ==============================
    always_comb begin
        logic [1:0] alloc_idx;
        alloc_idx = '0;
        for (int k = 0; k < LANES; k++) begin
            rd_phys_o[k] = '0;
            if (lane_wr[k]) begin
                rd_phys_o[k] = head_phys[alloc_idx];
                alloc_idx    = alloc_idx + 2'd1;
            end
            rs1_phys_o[k] = rat_q[rs1_i[k]];
            rs2_phys_o[k] = rat_q[rs2_i[k]];
            // Youngest older writer in the group overrides the table
            for (int j = 0; j < k; j++) begin
                if (lane_wr[j] && (rd_i[j] == rs1_i[k])) begin
                    rs1_phys_o[k] = rd_phys_o[j];
                end
                if (lane_wr[j] && (rd_i[j] == rs2_i[k])) begin
                    rs2_phys_o[k] = rd_phys_o[j];
                end
            end
        end
    end

    // Later lanes win on the same rd
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                rat_q[r] <= PHYS_W'(r);
            end
        end else if (accept_o) begin
            for (int k = 0; k < LANES; k++) begin
                if (lane_wr[k]) begin
                    rat_q[rd_i[k]] <= rd_phys_o[k];
                end
            end
        end
    end

    free_list u_free_list (
        .clk         (clk),
        .reset       (reset),
        .pop_i       (pop),
        .push_i      (commit_valid_i),
        .push_phys_i (commit_phys_i),
        .head_phys_o (head_phys),
        .count_o     (free_cnt)
    );

endmodule

// File: src/free_list.sv
`timescale 1ns/100ps

module free_list (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic [rename_pkg::LANES-1:0]                          pop_i,
    input  logic [rename_pkg::LANES-1:0]                          push_i,
    input  logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]  push_phys_i,
    output logic [rename_pkg::LANES-1:0][rename_pkg::PHYS_W-1:0]  head_phys_o,
    output logic [rename_pkg::FREE_CNT_W-1:0]                     count_o
);

    import rename_pkg::*;

    logic [PHYS_W-1:0]                      entries_q [FREE_REGS];
    // One extra bit so that full and empty differ
    logic [FREE_CNT_W-1:0]                  head_q;
    logic [FREE_CNT_W-1:0]                  tail_q;
    logic [FREE_CNT_W-1:0]                  pop_cnt;
    logic [FREE_CNT_W-1:0]                  push_cnt;
    logic [LANES-1:0][FREE_CNT_W-2:0]       push_addr;

    assign count_o = tail_q - head_q;

    // Next free registers in FIFO order
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            head_phys_o[k] = entries_q[head_q[FREE_CNT_W-2:0] + (FREE_CNT_W-1)'(k)];
        end
    end

    // Pushes are packed behind the tail in lane order
    always_comb begin
        pop_cnt  = '0;
        push_cnt = '0;
        for (int k = 0; k < LANES; k++) begin
            push_addr[k] = tail_q[FREE_CNT_W-2:0] + push_cnt[FREE_CNT_W-2:0];
            pop_cnt      = pop_cnt + FREE_CNT_W'(pop_i[k]);
            push_cnt     = push_cnt + FREE_CNT_W'(push_i[k]);
        end
    end

    // ==============================
    // Buffer and pointers
    // ==============================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < FREE_REGS; i++) begin
                entries_q[i] <= PHYS_W'(ARCH_REGS + i);
            end
            head_q <= '0;
            tail_q <= FREE_CNT_W'(FREE_REGS);
        end else begin
            for (int k = 0; k < LANES; k++) begin
                if (push_i[k]) begin
                    entries_q[push_addr[k]] <= push_phys_i[k];
                end
            end
            head_q <= head_q + pop_cnt;
            tail_q <= tail_q + push_cnt;
        end
    end

endmodule

// File: src/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  isa_pkg::instr_u                 instr_i,
    output logic [isa_pkg::CLASS_W-1:0]     class_o,
    output logic                            writes_rd_o,
    output logic [rename_pkg::ARCH_W-1:0]   rs1_o,
    output logic [rename_pkg::ARCH_W-1:0]   rs2_o,
    output logic [rename_pkg::ARCH_W-1:0]   rd_o,
    output logic [isa_pkg::XLEN-1:0]        immediate_o
);

    import isa_pkg::*;

    logic uses_imm12;

    // Register fields sit at the same place in every format
    assign rs1_o = instr_i.r.rs1;
    assign rs2_o = instr_i.r.rs2;
    assign rd_o  = instr_i.r.rd;

    // ==============================
    // Opcode to class
    // ==============================
    always_comb begin
        case (instr_i.r.opcode)
            OP_REG:           class_o = CLS_ALU;
            OP_IMM:           class_o = CLS_ALU_IMM;
            OP_LOAD:          class_o = CLS_LOAD;
            OP_STORE:         class_o = CLS_STORE;
            OP_BRANCH:        class_o = CLS_BRANCH;
            OP_JAL, OP_JALR:  class_o = CLS_JUMP;
            OP_LUI, OP_AUIPC: class_o = CLS_UPPER;
            default:          class_o = CLS_ILLEGAL;
        endcase
    end

    // Writes to x0 are dropped here so rename never allocates for them
    always_comb begin
        case (class_o)
            CLS_ALU, CLS_ALU_IMM, CLS_LOAD, CLS_JUMP, CLS_UPPER: begin
                writes_rd_o = (instr_i.r.rd != '0);
            end
            default: begin
                writes_rd_o = 1'b0;
            end
        endcase
    end

    // ==============================
    // I-format immediate
    // ==============================
    assign uses_imm12 = (class_o == CLS_ALU_IMM) || (class_o == CLS_LOAD) ||
                        (instr_i.i.opcode == OP_JALR);

    assign immediate_o = uses_imm12 ?
                         {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12} : '0;

endmodule

// File: src/rename_pkg.sv
package rename_pkg;

    // ==============================
    // Superscalar group width
    // ==============================
    localparam int LANES = 3;

    // ==============================
    // Register file sizes
    // ==============================
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    localparam int ARCH_W = $clog2(ARCH_REGS);
    localparam int PHYS_W = $clog2(PHYS_REGS);

    // Physical registers not mapped after reset
    localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

    // Holds 0 up to FREE_REGS inclusive
    localparam int FREE_CNT_W = $clog2(FREE_REGS + 1);

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

    // ==============================
    // Base ISA widths and opcodes
    // ==============================
    localparam int XLEN = 32;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // ==============================
    // Operation classes
    // ==============================
    localparam int CLASS_W = 3;

    localparam logic [CLASS_W-1:0] CLS_ALU     = 3'd0;
    localparam logic [CLASS_W-1:0] CLS_ALU_IMM = 3'd1;
    localparam logic [CLASS_W-1:0] CLS_LOAD    = 3'd2;
    localparam logic [CLASS_W-1:0] CLS_STORE   = 3'd3;
    localparam logic [CLASS_W-1:0] CLS_BRANCH  = 3'd4;
    localparam logic [CLASS_W-1:0] CLS_JUMP    = 3'd5;
    localparam logic [CLASS_W-1:0] CLS_UPPER   = 3'd6;
    localparam logic [CLASS_W-1:0] CLS_ILLEGAL = 3'd7;

    // Two views of the same instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_u;

endpackage
